/* pkt_match_defines.svh */
////////////////////////////////////////////////////////////////////////////
// Widths and counts shared by the packet classifier, included by the
// package and by every module that sizes a loop or a port from them
////////////////////////////////////////////////////////////////////////////

`ifndef PKT_MATCH_DEFINES_SVH
`define PKT_MATCH_DEFINES_SVH

// Byte and word geometry of the stream
`define BYTE_W        8
`define WORD_BYTES    8
// Index of the last valid byte, only meaningful on eop
`define LEN_W         3

// Packet type is 4 bytes and may not straddle two words
`define TYPE_BYTES    4
`define TYPE_MAX_OFF  4

// Symbol table and per-packet counters
`define SYM_ENTRIES   4
`define WORD_OFF_W    8
`define BUFFER_W      16

`endif

/* pkt_match_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Stream, operand and output types of the packet classifier, plus the
// helper that turns an eop length into a byte-valid mask
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pkt_match_defines.svh"

package pkt_match_pkg;

  // One 8-byte word, byte 0 in the low bits
  typedef logic [`WORD_BYTES-1:0][`BYTE_W-1:0] data_t;

  // Input beat as seen on the wire
  typedef struct packed {
    logic              sop;
    logic              eop;
    logic [`LEN_W-1:0] length;
    data_t             data;
  } in_t;

  typedef logic [`BUFFER_W-1:0]   buffer_t;
  typedef logic [`WORD_OFF_W-1:0] word_off_t;

  // Output word, the input fields plus the reported buffer
  typedef struct packed {
    logic              sop;
    logic              eop;
    logic [`LEN_W-1:0] length;
    data_t             data;
    buffer_t           buffer;
  } out_t;

  // Where the packet type lives: word index and start byte
  typedef struct packed {
    word_off_t         word;
    logic [`LEN_W-1:0] off;
  } packet_off_t;

  typedef logic [`TYPE_BYTES-1:0][`BYTE_W-1:0] packet_type_t;

  // One symbol table entry
  typedef struct packed {
    logic      valid;
    word_off_t off;
    data_t     match;
    buffer_t   buffer;
  } sym_match_t;

  // Operands held for the duration of one packet
  typedef struct packed {
    packet_off_t                        type_off;
    packet_type_t                       pkt_type;
    sym_match_t [`SYM_ENTRIES-1:0]      sym;
  } oprand_t;

  // Framed word handed from the framer to the match logic
  typedef struct packed {
    logic      matchable;
    logic      first;
    logic      last;
    word_off_t word_off;
    in_t       word;
  } beat_t;

  typedef enum logic {
    IDLE,
    IN_PACKET
  } framer_state_t;

  // Bytes 0 up to and including length are valid
  function automatic logic [`WORD_BYTES-1:0] len_to_mask(input logic [`LEN_W-1:0] length);
    logic [`WORD_BYTES-1:0] mask;
    for (int i = 0; i < `WORD_BYTES; i++) begin
      mask[i] = (i <= int'(length));
    end
    return mask;
  endfunction

endpackage

`default_nettype wire

/* pkt_framer.sv */
////////////////////////////////////////////////////////////////////////////
// Input register and packet framing; tracks the word offset and holds
// the match operands sampled with the sop word of each packet
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pkt_match_defines.svh"

module pkt_framer (
  input  logic                                        clk_net,
  input  logic                                        rst_net,
  input  logic                                        in_vld,
  input  pkt_match_pkg::in_t                          in,
  input  pkt_match_pkg::packet_off_t                  type_off,
  input  pkt_match_pkg::packet_type_t                 pkt_type,
  input  pkt_match_pkg::sym_match_t [`SYM_ENTRIES-1:0] sym_match,
  output pkt_match_pkg::beat_t                        beat,
  output pkt_match_pkg::oprand_t                      oprand
);

  import pkt_match_pkg::*;

  // Registered input beat
  logic          in_vld_r;
  in_t           in_r;

  framer_state_t state_r;
  framer_state_t state_nxt;
  word_off_t     word_off_r;
  oprand_t       oprand_r;

  // Registered word belongs to a packet
  logic          accept;
  // Incoming beat will open a new packet next cycle
  logic          oprand_en;

  always_comb begin
    accept    = 1'b0;
    state_nxt = state_r;
    case (state_r)
      IDLE: begin
        // Only a sop word may open a packet, anything else is dropped
        accept = in_vld_r & in_r.sop;
        if (accept && !in_r.eop) begin
          state_nxt = IN_PACKET;
        end
      end
      IN_PACKET: begin
        // Every valid word is body until the tail
        accept = in_vld_r;
        if (accept && in_r.eop) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase

    // Sample operands on the edge that loads an accepted sop word
    oprand_en = in_vld & in.sop & (state_nxt == IDLE);
  end

  always_comb begin
    beat.matchable = accept;
    beat.first     = accept & (state_r == IDLE);
    beat.last      = accept & in_r.eop;
    beat.word_off  = word_off_r;
    beat.word      = in_r;
    oprand         = oprand_r;
  end

  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      in_vld_r <= 1'b0;
      state_r  <= IDLE;
    end else begin
      in_vld_r <= in_vld;
      state_r  <= state_nxt;
    end
  end

  // Payload is only loaded with a valid beat
  always_ff @(posedge clk_net) begin
    if (in_vld) begin
      in_r <= in;
    end
  end

  // Word offset restarts at the sop word, wraps on long packets
  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      word_off_r <= '0;
    end else if (oprand_en) begin
      word_off_r <= '0;
    end else if (accept) begin
      word_off_r <= word_off_r + word_off_t'(1);
    end
  end

  always_ff @(posedge clk_net) begin
    if (oprand_en) begin
      oprand_r.type_off <= type_off;
      oprand_r.pkt_type <= pkt_type;
      oprand_r.sym      <= sym_match;
    end
  end

endmodule

`default_nettype wire

/* type_matcher.sv */
////////////////////////////////////////////////////////////////////////////
// Combinational search for the 4-byte packet type at the configured
// word and start byte of the current framed word
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pkt_match_defines.svh"

module type_matcher (
  input  pkt_match_pkg::beat_t   beat,
  input  pkt_match_pkg::oprand_t oprand,
  output logic                   type_found
);

  import pkt_match_pkg::*;

  // Valid bytes of the current word
  logic [`WORD_BYTES-1:0]   valid_mask;
  // Type present at each legal start byte
  logic [`TYPE_MAX_OFF:0]   found_pos;
  logic                     in_word;
  logic                     sel_found;

  always_comb begin
    // Length only trims the tail word
    valid_mask = beat.word.eop ? len_to_mask(beat.word.length) : '1;

    // Type expected somewhere in this word
    in_word = (beat.word_off == oprand.type_off.word);

    // Starts 0..4 keep all 4 bytes inside one word
    for (int i = 0; i <= `TYPE_MAX_OFF; i++) begin
      found_pos[i] = 1'b1;
      for (int j = 0; j < `TYPE_BYTES; j++) begin
        found_pos[i] &= valid_mask[i + j]
                        & (oprand.pkt_type[j] == beat.word.data[i + j]);
      end
    end

    // One-hot select of the configured start byte
    // Starts above TYPE_MAX_OFF select nothing and never match
    sel_found = 1'b0;
    for (int i = 0; i <= `TYPE_MAX_OFF; i++) begin
      sel_found |= (int'(oprand.type_off.off) == i) & found_pos[i];
    end

    type_found = beat.matchable & in_word & sel_found;
  end

endmodule

`default_nettype wire

/* symbol_matcher.sv */
////////////////////////////////////////////////////////////////////////////
// Combinational compare of the current word against the symbol table;
// the highest-index hitting entry supplies the buffer value
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pkt_match_defines.svh"

module symbol_matcher (
  input  pkt_match_pkg::beat_t   beat,
  input  pkt_match_pkg::oprand_t oprand,
  output logic                   sym_found,
  output pkt_match_pkg::buffer_t sym_buffer
);

  import pkt_match_pkg::*;

  // Symbol is a full 8 bytes, so the whole word must be valid
  logic                     full_word;
  // Entry configured and aimed at this word
  logic [`SYM_ENTRIES-1:0]  can_match;
  logic [`SYM_ENTRIES-1:0]  hit;
  logic                     any_hit;
  buffer_t                  hit_buffer;

  always_comb begin
    // Last byte index all ones means length covers the word
    full_word = ~beat.word.eop | (&beat.word.length);

    for (int i = 0; i < `SYM_ENTRIES; i++) begin
      can_match[i] = oprand.sym[i].valid
                     & (beat.word_off == oprand.sym[i].off);
      hit[i]       = can_match[i] & (beat.word.data == oprand.sym[i].match);
    end

    // Explicit flag, a zero buffer is still a legal match
    any_hit = |hit;

    // Ascending scan so the highest index wins
    hit_buffer = '0;
    for (int i = 0; i < `SYM_ENTRIES; i++) begin
      if (hit[i]) begin
        hit_buffer = oprand.sym[i].buffer;
      end
    end

    sym_found  = beat.matchable & full_word & any_hit;
    sym_buffer = hit_buffer;
  end

endmodule

`default_nettype wire

/* match_tracker.sv */
////////////////////////////////////////////////////////////////////////////
// Collects type and symbol hits across a packet and registers the output
// word; the buffer is reported on eop only when both were seen
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module match_tracker (
  input  logic                   clk_net,
  input  logic                   rst_net,
  input  pkt_match_pkg::beat_t   beat,
  input  logic                   type_found,
  input  logic                   sym_found,
  input  pkt_match_pkg::buffer_t sym_buffer,
  output logic                   out_vld,
  output pkt_match_pkg::out_t    out
);

  import pkt_match_pkg::*;

  // Match state carried from word to word
  typedef struct packed {
    logic    got_type;
    logic    got_symbol;
    buffer_t buffer;
  } match_t;

  match_t match_r;
  // State seen by this word, cleared on a packet's first word
  match_t match_base;
  // State including this word's hits
  match_t match_w;
  out_t   out_w;

  always_comb begin
    match_base = beat.first ? '0 : match_r;

    match_w.got_type   = match_base.got_type | type_found;
    match_w.got_symbol = match_base.got_symbol | sym_found;
    // Later symbol hit replaces an earlier one
    match_w.buffer     = sym_found ? sym_buffer : match_base.buffer;

    out_w.sop    = beat.word.sop;
    out_w.eop    = beat.word.eop;
    out_w.length = beat.word.length;
    out_w.data   = beat.word.data;
    out_w.buffer = (beat.last & match_w.got_type & match_w.got_symbol)
                   ? match_w.buffer : '0;
  end

  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      match_r <= '0;
    end else if (beat.matchable) begin
      match_r <= match_w;
    end
  end

  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= beat.matchable;
    end
  end

  // Output payload only moves with an accepted word
  always_ff @(posedge clk_net) begin
    if (beat.matchable) begin
      out <= out_w;
    end
  end

endmodule

`default_nettype wire

/* pkt_match.sv */
////////////////////////////////////////////////////////////////////////////
// Packet classifier top level; two-cycle stream from input to output
// with the matched buffer value reported on the eop word
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pkt_match_defines.svh"

module pkt_match (
  input  logic                                        clk_net,
  input  logic                                        rst_net,
  input  logic                                        in_vld,
  input  pkt_match_pkg::in_t                          in,
  input  pkt_match_pkg::packet_off_t                  type_off,
  input  pkt_match_pkg::packet_type_t                 pkt_type,
  input  pkt_match_pkg::sym_match_t [`SYM_ENTRIES-1:0] sym_match,
  output logic                                        out_vld,
  output pkt_match_pkg::out_t                         out
);

  import pkt_match_pkg::*;

  // Framed word and its packet operands
  beat_t   beat;
  oprand_t oprand;

  // Per-word match results
  logic    type_found;
  logic    sym_found;
  buffer_t sym_buffer;

  // Input register and framing, one cycle
  pkt_framer u_framer (
    .clk_net   (clk_net),
    .rst_net   (rst_net),
    .in_vld    (in_vld),
    .in        (in),
    .type_off  (type_off),
    .pkt_type  (pkt_type),
    .sym_match (sym_match),
    .beat      (beat),
    .oprand    (oprand)
  );

  type_matcher u_type (
    .beat       (beat),
    .oprand     (oprand),
    .type_found (type_found)
  );

  symbol_matcher u_symbol (
    .beat       (beat),
    .oprand     (oprand),
    .sym_found  (sym_found),
    .sym_buffer (sym_buffer)
  );

  // Match accumulation and output register, one cycle
  match_tracker u_tracker (
    .clk_net    (clk_net),
    .rst_net    (rst_net),
    .beat       (beat),
    .type_found (type_found),
    .sym_found  (sym_found),
    .sym_buffer (sym_buffer),
    .out_vld    (out_vld),
    .out        (out)
  );

endmodule

`default_nettype wire

/* tb_pkt_match.sv */
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the packet classifier; drives packets on the
// falling edge and checks every output word against a reference model
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pkt_match_defines.svh"

module tb_pkt_match;

  timeunit 1ns;
  timeprecision 1ps;

  import pkt_match_pkg::*;

  localparam int           MAX_WORDS   = 16;
  localparam int           DRAIN_LIMIT = 40;
  localparam packet_type_t TYPE_A      = 32'h88c7_5a3e;

  logic                          clk_net;
  logic                          rst_net;
  logic                          in_vld;
  in_t                           in;
  packet_off_t                   type_off;
  packet_type_t                  pkt_type;
  sym_match_t [`SYM_ENTRIES-1:0] sym_match;
  logic                          out_vld;
  out_t                          out;

  // Operands applied with the sop word, and the set swapped in after it
  packet_off_t                   cfg_type_off;
  packet_type_t                  cfg_pkt_type;
  sym_match_t [`SYM_ENTRIES-1:0] cfg_sym;
  packet_off_t                   alt_type_off;
  packet_type_t                  alt_pkt_type;
  sym_match_t [`SYM_ENTRIES-1:0] alt_sym;

  // Words of the next packet and their expected buffers
  data_t   pkt_data [MAX_WORDS];
  buffer_t exp_buf  [MAX_WORDS];
  // Expected output words with the cycle each is due
  out_t    exp_q [$];
  int      due_q [$];
  int      cyc = 0;
  integer  seed;

  pkt_match dut0 (
    .clk_net   (clk_net),
    .rst_net   (rst_net),
    .in_vld    (in_vld),
    .in        (in),
    .type_off  (type_off),
    .pkt_type  (pkt_type),
    .sym_match (sym_match),
    .out_vld   (out_vld),
    .out       (out)
  );

  initial begin
    clk_net = 1'b0;
    forever #2 clk_net = ~clk_net;
  end

  // Rising edges since time zero
  always @(posedge clk_net) begin
    cyc <= cyc + 1;
  end

  task automatic abort_run(input string why);
    $display("TEST FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic check_vld(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %b got %b", $time, name, exp, act);
      abort_run("Output valid does not follow the accepted input words");
    end
  endtask

  task automatic check_buffer(input string name, input buffer_t exp, input buffer_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, act);
      abort_run("Reported buffer value is wrong");
    end
  endtask

  task automatic check_out(input string name, input out_t exp, input out_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, act);
      abort_run("Output word differs from the input word");
    end
  endtask

  // Every falling edge either a due word or silence
  initial begin : monitor
    out_t exp_word;
    forever begin
      @(negedge clk_net);
      if (!rst_net) begin
        if (due_q.size() != 0 && due_q[0] == cyc) begin
          check_vld("out_vld", 1'b1, out_vld);
          exp_word = exp_q.pop_front();
          due_q.delete(0);
          check_buffer("out.buffer", exp_word.buffer, out.buffer);
          check_out("out", exp_word, out);
        end else begin
          check_vld("out_vld", 1'b0, out_vld);
        end
      end
    end
  end

  task automatic clear_cfg();
    cfg_type_off      = '0;
    // Type word far beyond any test packet
    cfg_type_off.word = 8'd200;
    cfg_pkt_type      = TYPE_A;
    cfg_sym           = '0;
    alt_type_off      = '0;
    alt_pkt_type      = ~TYPE_A;
    alt_sym           = '0;
  endtask

  task automatic fill_packet(input int n);
    for (int i = 0; i < n; i++) begin
      pkt_data[i] = {$random(seed), $random(seed)};
    end
  endtask

  // Plants the type bytes that fit in the word and points the operands at them
  task automatic put_type(input int word, input int off);
    cfg_type_off.word = word_off_t'(word);
    cfg_type_off.off  = off[`LEN_W-1:0];
    for (int j = 0; j < `TYPE_BYTES; j++) begin
      if (off + j < `WORD_BYTES) begin
        pkt_data[word][off + j] = cfg_pkt_type[j];
      end
    end
  endtask

  task automatic put_sym(input int k, input int word, input buffer_t buf_val);
    cfg_sym[k].valid  = 1'b1;
    cfg_sym[k].off    = word_off_t'(word);
    cfg_sym[k].match  = pkt_data[word];
    cfg_sym[k].buffer = buf_val;
  endtask

  // Reference rule for the buffer each word of the packet carries
  task automatic model_packet(input int n, input logic [`LEN_W-1:0] last_len);
    logic    got_type;
    logic    got_sym;
    logic    is_last;
    logic    type_ok;
    logic    found;
    buffer_t kept;
    buffer_t hit_buf;
    int      b;
    got_type = 1'b0;
    got_sym  = 1'b0;
    kept     = '0;
    for (int i = 0; i < n; i++) begin
      is_last = (i == n - 1);
      // Four type bytes, all inside the word and inside the valid length
      type_ok = (i == int'(cfg_type_off.word)) && (int'(cfg_type_off.off) <= 4);
      if (type_ok) begin
        for (int j = 0; j < 4; j++) begin
          b = int'(cfg_type_off.off) + j;
          if ((is_last && b > int'(last_len)) || pkt_data[i][b] != cfg_pkt_type[j]) begin
            type_ok = 1'b0;
          end
        end
      end
      // Symbols need all 8 bytes; first hit from the top index wins
      found   = 1'b0;
      hit_buf = '0;
      if (!is_last || last_len == 3'd7) begin
        for (int k = `SYM_ENTRIES - 1; k >= 0; k--) begin
          if (!found && cfg_sym[k].valid && int'(cfg_sym[k].off) == i
              && cfg_sym[k].match == pkt_data[i]) begin
            found   = 1'b1;
            hit_buf = cfg_sym[k].buffer;
          end
        end
      end
      got_type = got_type | type_ok;
      if (found) begin
        got_sym = 1'b1;
        kept    = hit_buf;
      end
      exp_buf[i] = (is_last && got_type && got_sym) ? kept : '0;
    end
  endtask

  task automatic send_packet(input int n, input logic [`LEN_W-1:0] last_len,
                             input logic swap_ops);
    in_t  word;
    out_t exp_word;
    model_packet(n, last_len);
    for (int i = 0; i < n; i++) begin
      @(negedge clk_net);
      word.sop    = (i == 0);
      word.eop    = (i == n - 1);
      word.length = (i == n - 1) ? last_len : '0;
      word.data   = pkt_data[i];
      in_vld      = 1'b1;
      in          = word;
      // Operands move at sop, or after it when swapped on purpose
      if (i == 0) begin
        type_off  = cfg_type_off;
        pkt_type  = cfg_pkt_type;
        sym_match = cfg_sym;
      end else if (swap_ops) begin
        type_off  = alt_type_off;
        pkt_type  = alt_pkt_type;
        sym_match = alt_sym;
      end
      exp_word.sop    = word.sop;
      exp_word.eop    = word.eop;
      exp_word.length = word.length;
      exp_word.data   = word.data;
      exp_word.buffer = exp_buf[i];
      exp_q.push_back(exp_word);
      due_q.push_back(cyc + 2);
    end
  endtask

  // Valid words without sop, outside any packet
  task automatic send_stray(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk_net);
      in_vld    = 1'b1;
      in.sop    = 1'b0;
      in.eop    = (i == n - 1);
      in.length = 3'd7;
      in.data   = {$random(seed), $random(seed)};
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clk_net);
    in_vld = 1'b0;
    while (exp_q.size() != 0) begin
      if (waited >= DRAIN_LIMIT) begin
        abort_run("Timeout waiting for the expected output words");
      end else begin
        waited++;
        @(negedge clk_net);
      end
    end
  endtask

  task automatic run_two_word(input int t_word, input int t_off, input int s_word,
                              input logic [`LEN_W-1:0] last_len, input logic s_valid);
    clear_cfg();
    fill_packet(2);
    put_type(t_word, t_off);
    put_sym(3, s_word, buffer_t'(16'h0600 + t_off));
    cfg_sym[3].valid = s_valid;
    send_packet(2, last_len, 1'b0);
  endtask

  task automatic test_reset_passthrough();
    check_vld("out_vld", 1'b0, out_vld);
    clear_cfg();
    fill_packet(1);
    send_packet(1, 3'd5, 1'b0);
    fill_packet(4);
    send_packet(4, 3'd2, 1'b0);
    fill_packet(9);
    send_packet(9, 3'd7, 1'b0);
    drain();
  endtask

  task automatic test_full_match();
    // Type in word 1 at every legal start, symbol in word 3
    for (int off = 0; off <= `TYPE_MAX_OFF; off++) begin
      clear_cfg();
      fill_packet(5);
      put_type(1, off);
      put_sym(2, 3, buffer_t'(16'h1a00 + off));
      send_packet(5, 3'd7, 1'b0);
    end
    // Type and symbol share the only word
    clear_cfg();
    fill_packet(1);
    put_type(0, 2);
    put_sym(0, 0, 16'hbeef);
    send_packet(1, 3'd7, 1'b0);
    drain();
  endtask

  task automatic test_partial_match();
    // Type only, the entry aims at data that never appears
    clear_cfg();
    fill_packet(3);
    put_type(0, 0);
    put_sym(1, 2, 16'h0bad);
    cfg_sym[1].match = ~pkt_data[2];
    send_packet(3, 3'd7, 1'b0);
    // Symbol only, random filler where the type should be
    clear_cfg();
    fill_packet(3);
    cfg_type_off.word = 8'd0;
    cfg_type_off.off  = 3'd1;
    put_sym(3, 2, 16'h0bad);
    send_packet(3, 3'd7, 1'b0);
    // Matching operands at sop, blank ones after it
    clear_cfg();
    fill_packet(4);
    put_type(0, 3);
    put_sym(2, 1, 16'h7e57);
    send_packet(4, 3'd7, 1'b1);
    // Blank symbols at sop, matching ones after it
    clear_cfg();
    fill_packet(4);
    put_type(0, 3);
    put_sym(2, 1, 16'h7e58);
    alt_type_off = cfg_type_off;
    alt_pkt_type = cfg_pkt_type;
    alt_sym      = cfg_sym;
    cfg_sym      = '0;
    send_packet(4, 3'd7, 1'b1);
    drain();
  endtask

  task automatic test_range_rules();
    // Start byte 5 runs past the word
    run_two_word(0, 5, 1, 3'd7, 1'b1);
    // Type ends at byte 6 of the eop word, cut by length 5, kept by 6
    run_two_word(1, 3, 0, 3'd5, 1'b1);
    run_two_word(1, 3, 0, 3'd6, 1'b1);
    // Symbol in a short eop word
    run_two_word(0, 0, 1, 3'd6, 1'b1);
    // Entry switched off
    run_two_word(0, 0, 1, 3'd7, 1'b0);
    drain();
  endtask

  task automatic test_priority();
    // Entries 0, 1 and 3 all hit word 1
    clear_cfg();
    fill_packet(3);
    put_type(0, 1);
    put_sym(0, 1, 16'h0100);
    put_sym(1, 1, 16'h0111);
    put_sym(3, 1, 16'h0333);
    send_packet(3, 3'd7, 1'b0);
    // Later word replaces the earlier hit, even from a lower index
    clear_cfg();
    fill_packet(4);
    put_type(0, 4);
    put_sym(3, 1, 16'haaaa);
    put_sym(0, 2, 16'h5555);
    send_packet(4, 3'd7, 1'b0);
    drain();
  endtask

  task automatic test_framing();
    clear_cfg();
    send_stray(3);
    fill_packet(3);
    put_type(0, 0);
    put_sym(1, 2, 16'hc0c0);
    send_packet(3, 3'd7, 1'b0);
    // Symbol only, straight after a full match
    clear_cfg();
    fill_packet(3);
    put_sym(0, 1, 16'h0d0d);
    send_packet(3, 3'd7, 1'b0);
    send_stray(2);
    // Type only
    clear_cfg();
    fill_packet(2);
    put_type(1, 2);
    send_packet(2, 3'd7, 1'b0);
    drain();
  endtask

  initial begin
    seed      = 32'h0c138788;
    rst_net   = 1'b1;
    in_vld    = 1'b0;
    in        = '0;
    type_off  = '0;
    pkt_type  = '0;
    sym_match = '0;
    repeat (3) @(posedge clk_net);
    @(negedge clk_net);
    rst_net = 1'b0;

    test_reset_passthrough();
    test_full_match();
    test_partial_match();
    test_range_rules();
    test_priority();
    test_framing();

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* pkt_match.f */
+incdir+.
pkt_match_pkg.sv
pkt_framer.sv
type_matcher.sv
symbol_matcher.sv
match_tracker.sv
pkt_match.sv
tb_pkt_match.sv

/* run.sh */
#!/bin/sh
# Build and run the packet classifier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_pkt_match \
  -Mdir obj_dir -o sim_pkt_match -f pkt_match.f

# A failed run ends without the pass line, so the search decides
sim_out=$(./obj_dir/sim_pkt_match 2>&1) || true
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "TEST PASS"
